// File: Bender.yml
package:
  name: apb_cache

sources:
  - logic/cache_geom_pkg.sv
  - logic/cache_ctrl_pkg.sv
  - logic/cache_array_if.sv
  - logic/cache_init_counter.sv
  - logic/cache_tag_array.sv
  - logic/cache_data_array.sv
  - logic/cache_ctrl_fsm.sv
  - logic/apb_cache_top.sv
  - target: test
    files:
      - test/line_source_model.sv
      - test/tb_apb_cache.sv

// File: flist.f
logic/cache_geom_pkg.sv
logic/cache_ctrl_pkg.sv
logic/cache_array_if.sv
logic/cache_init_counter.sv
logic/cache_tag_array.sv
logic/cache_data_array.sv
logic/cache_ctrl_fsm.sv
logic/apb_cache_top.sv
test/line_source_model.sv
test/tb_apb_cache.sv

// File: logic/apb_cache_top.sv
// cache behind an APB slave; pslverr, pstrb and pprot are not provided, no access is accepted during init
`timescale 1ns/10ps

module apb_cache_top import cache_geom_pkg::*, cache_ctrl_pkg::*; (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      psel,
    input  logic                                      penable,
    input  logic                                      pwrite,
    input  apb_addr_t                                 paddr,
    input  word_t                                     pwdata,
    output word_t                                     prdata,
    output logic                                      pready,
    output logic                                      fill_req,
    output logic [$bits(tag_t)+$bits(index_t)-1:0]    fill_addr,
    input  logic                                      fill_ack,
    input  line_t                                     fill_line
);

    index_t init_index;
    logic   init_done;

    cache_array_if arr_if ();

    cache_init_counter i_init_counter (
        .clk        (clk),
        .arst_n     (arst_n),
        .init_index (init_index),
        .init_done  (init_done)
    );

    cache_ctrl_fsm i_ctrl_fsm (
        .clk        (clk),
        .arst_n     (arst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .fill_req   (fill_req),
        .fill_addr  (fill_addr),
        .fill_ack   (fill_ack),
        .fill_line  (fill_line),
        .init_index (init_index),
        .init_done  (init_done),
        .arr        (arr_if.ctrl)
    );

    cache_tag_array i_tag_array (
        .clk (clk),
        .arr (arr_if.tag_side)
    );

    cache_data_array i_data_array (
        .clk (clk),
        .arr (arr_if.data_side)
    );

endmodule

// File: logic/cache_array_if.sv
// controller-to-array bus; read fields are registered one cycle after index, writes land at the edge
`timescale 1ns/10ps

interface cache_array_if import cache_geom_pkg::*; ();

    index_t    index;                  // shared by tag and data arrays
    way_mask_t tag_we;                 // tag, valid and lru write per way
    logic      valid_wd;
    tag_t      tag_wd;
    way_mask_t data_we;                // line or word write per way
    logic      word_write;             // single word at offset instead of full line
    offset_t   offset;
    word_t     word_wd;
    line_t     line_wd;

    tag_t      tag_rd  [n_ways];
    way_mask_t valid_rd;               // one valid bit per way
    logic      lru_rd;                 // way to replace next
    line_t     line_rd [n_ways];

    modport ctrl (
        output index, tag_we, valid_wd, tag_wd, data_we, word_write, offset, word_wd, line_wd,
        input  tag_rd, valid_rd, lru_rd, line_rd
    );

    modport tag_side (
        input  index, tag_we, valid_wd, tag_wd,
        output tag_rd, valid_rd, lru_rd
    );

    modport data_side (
        input  index, data_we, word_write, offset, word_wd, line_wd,
        output line_rd
    );

endinterface

// File: logic/cache_ctrl_fsm.sv
// APB slave for the cache; read-allocate, write hits update one word, write misses are dropped
`timescale 1ns/10ps

module cache_ctrl_fsm import cache_geom_pkg::*, cache_ctrl_pkg::*; (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      psel,
    input  logic                                      penable,
    input  logic                                      pwrite,
    input  apb_addr_t                                 paddr,
    input  word_t                                     pwdata,
    output word_t                                     prdata,
    output logic                                      pready,
    output logic                                      fill_req,
    output logic [$bits(tag_t)+$bits(index_t)-1:0]    fill_addr,
    input  logic                                      fill_ack,
    input  line_t                                     fill_line,
    input  index_t                                    init_index,
    input  logic                                      init_done,
    cache_array_if.ctrl                               arr
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    tag_t      req_tag;
    index_t    req_index;
    offset_t   req_offset;
    way_mask_t hit_way;
    logic      hit;
    line_t     hit_line;
    way_mask_t victim;
    word_t     fill_word_q;      // requested word kept for respond

    function automatic word_t pick_word(line_t line, offset_t off);
        word_mask_t sel;
        word_t      w;
        sel = word_mask_t'(1) << off;
        w   = '0;
        for (int i = 0; i < words_per_line; i++) begin
            if (sel[i]) begin
                w = w | line[i*$bits(word_t) +: $bits(word_t)];
            end
        end
        return w;
    endfunction

    // master holds paddr for the whole access
    assign req_tag    = paddr[31:12];
    assign req_index  = paddr[11:4];
    assign req_offset = paddr[3:2];

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < n_ways; w++) begin
            hit_way[w] = arr.valid_rd[w] && (arr.tag_rd[w] == req_tag);
            if (hit_way[w]) begin
                hit_line = hit_line | arr.line_rd[w];
            end
        end
        hit    = |hit_way;
        victim = arr.lru_rd ? way_mask_t'(2'b10) : way_mask_t'(2'b01);
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_init:    if (init_done) state_nxt = st_idle;
            st_idle:    if (psel && !penable) state_nxt = st_lookup;  // setup phase
            st_lookup:  state_nxt = st_compare;
            st_compare: state_nxt = (pwrite || hit) ? st_idle : st_refill;
            st_refill:  if (fill_ack) state_nxt = st_respond;
            st_respond: state_nxt = st_idle;
            default:    state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_init;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_refill && fill_ack) begin
            fill_word_q <= pick_word(fill_line, req_offset);
        end
    end

    // array controls
    always_comb begin
        arr.index      = (state == st_init) ? init_index : req_index;
        arr.tag_we     = '0;
        arr.valid_wd   = 1'b0;
        arr.tag_wd     = req_tag;
        arr.data_we    = '0;
        arr.word_write = 1'b0;
        arr.offset     = req_offset;
        arr.word_wd    = pwdata;
        arr.line_wd    = fill_line;
        case (state)
            st_init: begin
                if (!init_done) arr.tag_we = '1;         // invalidate both ways
            end
            st_compare: begin
                if (pwrite && hit) begin
                    arr.data_we    = hit_way;
                    arr.word_write = 1'b1;
                end
            end
            st_refill: begin
                if (fill_ack) begin
                    arr.tag_we   = victim;
                    arr.valid_wd = 1'b1;
                    arr.data_we  = victim;
                end
            end
            default: ;
        endcase
    end

    assign pready    = ((state == st_compare) && (pwrite || hit)) || (state == st_respond);
    assign prdata    = (state == st_respond) ? fill_word_q : pick_word(hit_line, req_offset);
    assign fill_req  = (state == st_refill);
    assign fill_addr = {req_tag, req_index};

endmodule

// File: logic/cache_ctrl_pkg.sv
// controller state encoding and the APB address type; the address is a byte address
package cache_ctrl_pkg;

    // one access in flight at a time
    typedef enum logic [2:0] {
        st_init,      // valid bits being cleared after reset
        st_idle,      // waiting for an APB setup phase
        st_lookup,    // index presented to the arrays
        st_compare,   // tag match on the registered read
        st_refill,    // waiting for the line source
        st_respond    // returning the refilled word
    } ctrl_state_t;

    typedef logic [31:0] apb_addr_t;  // full byte address from the APB master

endpackage

// File: logic/cache_data_array.sv
// line storage split in word lanes; a word write touches one lane, a refill writes all four
`timescale 1ns/10ps

module cache_data_array import cache_geom_pkg::*; (
    input  logic                    clk,
    cache_array_if.data_side        arr
);

    word_t      data_mem [n_ways][words_per_line][n_sets];

    word_mask_t lane_sel;             // lanes hit by this write
    word_mask_t lane_we  [n_ways];
    line_t      lane_wd;

    always_comb begin
        if (arr.word_write) begin
            lane_sel = word_mask_t'(1) << arr.offset;
            lane_wd  = {words_per_line{arr.word_wd}};  // same word on every lane
        end else begin
            lane_sel = '1;
            lane_wd  = arr.line_wd;
        end
        for (int w = 0; w < n_ways; w++) begin
            lane_we[w] = arr.data_we[w] ? lane_sel : '0;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < n_ways; w++) begin
            for (int l = 0; l < words_per_line; l++) begin
                if (lane_we[w][l]) begin
                    data_mem[w][l][arr.index] <= lane_wd[l*$bits(word_t) +: $bits(word_t)];
                end
            end
        end
    end

    // registered read of the full line in each way
    always_ff @(posedge clk) begin
        for (int w = 0; w < n_ways; w++) begin
            for (int l = 0; l < words_per_line; l++) begin
                arr.line_rd[w][l*$bits(word_t) +: $bits(word_t)] <= data_mem[w][l][arr.index];
            end
        end
    end

endmodule

// File: logic/cache_geom_pkg.sv
// geometry of the 2-way, 256-set cache with 16-byte lines; word accesses only, no byte lanes
package cache_geom_pkg;

    localparam int n_sets         = 256;  // sets per way
    localparam int n_ways         = 2;    // associativity
    localparam int words_per_line = 4;    // 32-bit words in one line

    // set index, address bits [11:4]
    typedef logic [7:0]   index_t;

    // address tag, address bits [31:12]
    typedef logic [19:0]  tag_t;

    // word within a line, address bits [3:2]
    typedef logic [1:0]   offset_t;

    typedef logic [31:0]  word_t;         // one data word
    typedef logic [127:0] line_t;         // word 0 in the low lanes

    typedef logic [1:0]   way_mask_t;     // bit w selects way w
    typedef logic [3:0]   word_mask_t;    // bit i selects word lane i

endpackage

// File: logic/cache_init_counter.sv
// walks every set index once after reset; holds the last index and init_done until the next reset
`timescale 1ns/10ps

module cache_init_counter import cache_geom_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    output index_t init_index,
    output logic   init_done
);

    index_t count;
    logic   done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            done  <= 1'b0;
        end else if (!done) begin
            if (count == index_t'(n_sets - 1)) begin
                done <= 1'b1;             // one cycle after the last set
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    assign init_index = count;
    assign init_done  = done;

endmodule

// File: logic/cache_tag_array.sv
// tag, valid and lru storage with registered read; the SRAMs power up unknown and need the init sweep
`timescale 1ns/10ps

module cache_tag_array import cache_geom_pkg::*; (
    input  logic                    clk,
    cache_array_if.tag_side         arr
);

    // {valid, tag} per way and set
    logic [$bits(tag_t):0] entry_mem [n_ways][n_sets];
    logic                  lru_mem   [n_sets];

    logic lru_we;
    logic lru_wd;

    // lru points at the way to fill next
    always_comb begin
        lru_we = |arr.tag_we;
        lru_wd = (arr.tag_we == way_mask_t'(2'b01));  // way 0 alone, so way 1 is next
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < n_ways; w++) begin
            if (arr.tag_we[w]) begin
                entry_mem[w][arr.index] <= {arr.valid_wd, arr.tag_wd};
            end
        end
        if (lru_we) begin
            lru_mem[arr.index] <= lru_wd;
        end
    end

    // registered read, old contents on a same-cycle write
    always_ff @(posedge clk) begin
        for (int w = 0; w < n_ways; w++) begin
            {arr.valid_rd[w], arr.tag_rd[w]} <= entry_mem[w][arr.index];
        end
        arr.lru_rd <= lru_mem[arr.index];
    end

endmodule

// File: test/line_source_model.sv
// read-only line source; serves one request at a time and acks 1 to 8 cycles after seeing it
`timescale 1ns/10ps

module line_source_model import cache_geom_pkg::*; (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   fill_req,
    input  logic [$bits(tag_t)+$bits(index_t)-1:0] fill_addr,
    output logic                                   fill_ack,
    output line_t                                  fill_line
);

    logic [31:0] lcg_state;
    logic [3:0]  delay;         // cycles left until the ack
    logic        busy;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // word w of line address la
    function automatic line_t source_line(logic [$bits(tag_t)+$bits(index_t)-1:0] la);
        line_t l;
        for (int w = 0; w < words_per_line; w++) begin
            l[w*32 +: 32] = ((32'(la) << 2) + 32'(w)) ^ 32'hA5A5_0000;
        end
        return l;
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lcg_state <= 32'h9367_2608;
            busy      <= 1'b0;
            delay     <= '0;
            fill_ack  <= 1'b0;
            fill_line <= '0;
        end else begin
            fill_ack <= 1'b0;                           // single-cycle pulse
            if (fill_req && !busy && !fill_ack) begin
                busy      <= 1'b1;
                delay     <= {1'b0, lcg_state[18:16]} + 4'd1;
                lcg_state <= lcg_next(lcg_state);
            end else if (busy) begin
                if (delay == 4'd1) begin
                    busy      <= 1'b0;
                    fill_ack  <= 1'b1;
                    fill_line <= source_line(fill_addr);
                end else begin
                    delay <= delay - 4'd1;
                end
            end
        end
    end

endmodule

// File: test/tb_apb_cache.sv
// APB accesses start only after the init sweep; expected values come from a reference model of the cache
`timescale 1ns/10ps

module tb_apb_cache import cache_geom_pkg::*, cache_ctrl_pkg::*; ();

    logic      clk, arst_n;
    logic      psel, penable, pwrite, pready;
    apb_addr_t paddr;
    word_t     pwdata, prdata;
    logic      fill_req, fill_ack;
    logic [$bits(tag_t)+$bits(index_t)-1:0] fill_addr, exp_fill_addr;
    line_t     fill_line;

    logic      ref_valid [n_ways][n_sets];
    tag_t      ref_tag   [n_ways][n_sets];
    logic      ref_lru   [n_sets];
    word_t     ref_data  [n_ways][n_sets][words_per_line];

    word_t     exp_prdata;
    logic      exp_fast;                // hit or write, pready in the second access cycle
    int        acc_cycle = 1;
    logic      saw_fill  = 1'b0;

    apb_cache_top i_apb_cache_top (.*);

    line_source_model i_line_source (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        acc_cycle <= (psel && penable) ? acc_cycle + 1 : 1;
        saw_fill  <= (psel && !penable) ? 1'b0 : (saw_fill | fill_req);  // cleared per access
    end

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        $display("mismatch at %0t: %s expected %h, actual %h", $time, name, exp, act);
        abort_run();
    endtask

    assert property (@(posedge clk) disable iff (!arst_n) !psel |-> !pready)
        else report_mismatch("pready", 0, $sampled(pready));
    assert property (@(posedge clk) disable iff (!arst_n) !psel |-> !fill_req)
        else report_mismatch("fill_req", 0, $sampled(fill_req));
    assert property (@(posedge clk) disable iff (!arst_n)
        (psel && penable && exp_fast) |-> (pready == (acc_cycle == 2)))
        else report_mismatch("pready", $sampled(acc_cycle == 2), $sampled(pready));
    assert property (@(posedge clk) disable iff (!arst_n) (psel && exp_fast) |-> !fill_req)
        else report_mismatch("fill_req", 0, $sampled(fill_req));
    assert property (@(posedge clk) disable iff (!arst_n) fill_req |-> fill_addr == exp_fill_addr)
        else report_mismatch("fill_addr", $sampled(exp_fill_addr), $sampled(fill_addr));
    assert property (@(posedge clk) disable iff (!arst_n)
        (psel && penable && pready && !pwrite) |-> prdata == exp_prdata)
        else report_mismatch("prdata", $sampled(exp_prdata), $sampled(prdata));
    assert property (@(posedge clk) disable iff (!arst_n)
        (psel && penable && pready && !exp_fast) |-> saw_fill)
        else begin
            $display("read miss at %0t finished without a fill request", $time);
            abort_run();
        end

    function automatic word_t source_word(apb_addr_t a);
        return ((32'(a[31:4]) << 2) + 32'(a[3:2])) ^ 32'hA5A5_0000;
    endfunction

    task automatic apb_access(apb_addr_t addr, logic wr, word_t wd, logic fast, word_t rd_exp);
        int waited;
        @(posedge clk);
        psel          <= 1'b1;           // setup phase
        penable       <= 1'b0;
        paddr         <= addr;
        pwrite        <= wr;
        pwdata        <= wd;
        exp_fast      <= fast;
        exp_prdata    <= rd_exp;
        exp_fill_addr <= addr[31:4];
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!pready && waited < 40) begin
            waited++;
            @(negedge clk);
        end
        if (!pready) begin
            $display("timeout at %0t: no pready for address %h", $time, addr);
            abort_run();
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic cache_read(apb_addr_t a);
        index_t idx;
        int     way;
        idx = a[11:4];
        way = -1;
        for (int w = 0; w < n_ways; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == a[31:12]) way = w;
        end
        if (way < 0) begin
            way = ref_lru[idx] ? 1 : 0;     // refill into the lru way
            ref_valid[way][idx] = 1'b1;
            ref_tag[way][idx]   = a[31:12];
            for (int i = 0; i < words_per_line; i++) begin
                ref_data[way][idx][i] = source_word({a[31:4], offset_t'(i), 2'b00});
            end
            ref_lru[idx] = (way == 0);
            apb_access(a, 1'b0, '0, 1'b0, ref_data[way][idx][a[3:2]]);
        end else begin
            apb_access(a, 1'b0, '0, 1'b1, ref_data[way][idx][a[3:2]]);
        end
    endtask

    task automatic cache_write(apb_addr_t a, word_t d);
        index_t idx;
        idx = a[11:4];
        for (int w = 0; w < n_ways; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == a[31:12]) ref_data[w][idx][a[3:2]] = d;
        end
        apb_access(a, 1'b1, d, 1'b1, '0);   // write miss leaves the model alone
    endtask

    initial begin
        clk     = 1'b0;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int s = 0; s < n_sets; s++) begin
            ref_lru[s] = 1'b0;
            for (int w = 0; w < n_ways; w++) ref_valid[w][s] = 1'b0;
        end
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        repeat (n_sets + 4) @(posedge clk);          // init sweep and init_done
        cache_read(32'h0000_1038);                     // cold miss
        for (int i = 0; i < 4; i++) cache_read(32'h0000_1030 + 4 * i);
        cache_write(32'h0000_1034, 32'hDEAD_BEEF);     // write hit
        for (int i = 0; i < 4; i++) cache_read(32'h0000_1030 + 4 * i);
        cache_write(32'h0005_0090, 32'h1234_5678);     // write miss
        cache_read(32'h0005_0090);
        cache_read(32'h0001_0400);                     // A to way 0
        cache_read(32'h0002_0404);                     // B to way 1
        cache_read(32'h0003_0408);                     // C evicts A
        cache_read(32'h0002_040C);
        cache_read(32'h0001_0400);
        $display("All tests passed!");
        $finish;
    end

endmodule
